//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = rh11_tb
FILELIST  = rh11.f
OBJDIR    = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJDIR)

//--- common/drive_exec_if.sv
// ##############################
// drive exec link
// ##############################
`timescale 1ns/1ps

interface drive_exec_if import rh11_pkg::*; ();

    // scanned drive state from the register file
    logic [4:0] fc;         // function code
    logic       go;
    logic       fresh;      // go just written
    cyl_t       dc;         // desired cylinder
    cyl_t       cc;         // current cylinder
    rpda_t      da;

    // strobes for the scanned drive from the sequencer
    logic       finish;     // clear go, set dry
    logic       attn;       // set ata
    logic       err_iae;    // invalid address
    logic       err_ilf;    // illegal function
    logic       clr_status; // clear ata, err, rper1
    logic       set_vv;
    logic       preset;     // clear da and dc
    logic       load_cc;
    cyl_t       next_cc;
    logic       clr_fresh;
    logic       pip;        // positioning in progress

    modport regs (
        output fc, go, fresh, dc, cc, da,
        input  finish, attn, err_iae, err_ilf, clr_status, set_vv, preset,
        input  load_cc, next_cc, clr_fresh, pip
    );

    modport seq (
        input  fc, go, fresh, dc, cc, da,
        output finish, attn, err_iae, err_ilf, clr_status, set_vv, preset,
        output load_cc, next_cc, clr_fresh, pip
    );

endinterface

//--- common/rh11_pkg.sv
// ##############################
// rh11 shared definitions
// ##############################

package rh11_pkg;

    // sizes
    localparam int num_drives = 8;
    typedef logic [2:0]  drive_idx_t;   // drive number
    typedef logic [9:0]  cyl_t;         // cylinder number
    typedef logic [15:0] word_t;        // unibus word

    // rp06 geometry
    localparam cyl_t       max_cyl         = 10'd814;
    localparam logic [4:0] max_trk         = 5'd18;   // 19 tracks per cylinder
    localparam logic [4:0] max_sec         = 5'd21;   // 22 sectors per track
    localparam cyl_t       recal_start_cyl = 10'd999; // recal walks down from here

    // stepping
    localparam int step_period      = 64;   // scan rounds per step tick
    localparam int first_step_ticks = 42;   // settle before the first step

    // bus
    localparam logic [17:0] base_addr  = 18'o776700;
    localparam logic [7:0]  int_vector = 8'o254;

    // register word offsets in a_in_h[5:1]
    typedef enum logic [4:0] {
        reg_cs1 = 5'd0,
        reg_wc  = 5'd1,
        reg_ba  = 5'd2,
        reg_da  = 5'd3,
        reg_cs2 = 5'd4,
        reg_ds  = 5'd5,
        reg_er1 = 5'd6,
        reg_as  = 5'd7,
        reg_la  = 5'd8,
        reg_dt  = 5'd11,
        reg_sn  = 5'd12,
        reg_of  = 5'd13,
        reg_dc  = 5'd14,
        reg_cc  = 5'd15
    } reg_sel_e;

    // function codes in rpcs1[5:1]
    typedef enum logic [4:0] {
        fn_nop         = 5'd0,
        fn_unload      = 5'd1,
        fn_seek        = 5'd2,
        fn_recal       = 5'd3,
        fn_drive_clear = 5'd4,
        fn_release     = 5'd5,
        fn_preset      = 5'd8,
        fn_pack_ack    = 5'd9,
        fn_search      = 5'd12
    } func_e;

    // constant registers
    localparam word_t drive_type_rp06 = 16'o020022;
    localparam word_t offset_word     = 16'o010000;   // fmt16 set

    // sequencer state codes
    localparam logic [1:0] seq_idle  = 2'd0;
    localparam logic [1:0] seq_pos   = 2'd1;   // stepping toward dc
    localparam logic [1:0] seq_first = 2'd2;   // waiting for first step
    localparam logic [1:0] seq_recal = 2'd3;   // walking down to cyl 0

    // rpda as raw bus word or as drive fields
    typedef union packed {
        word_t raw;
        struct packed {
            logic [2:0] spare_hi;
            logic [4:0] trk;    // bits 12:8
            logic [2:0] spare_lo;
            logic [4:0] sec;    // bits 4:0
        } f;
    } rpda_t;

endpackage

//--- drive_exec/drive_sequencer.sv
// ##############################
// per-drive command sequencer
// ##############################
`timescale 1ns/1ps

module drive_sequencer import rh11_pkg::*; (
    input  logic       CLOCK,
    input  logic       RESET,
    input  drive_idx_t scan_drv,
    input  logic       step_tick,
    drive_exec_if.seq  ex
);

    logic [1:0] state [num_drives];
    logic [$clog2(first_step_ticks)-1:0] first_cnt [num_drives];
    logic [1:0] cur_state, nxt_state;
    logic [$clog2(first_step_ticks)-1:0] nxt_cnt;
    logic bad_addr;
    logic [num_drives-1:0] tick_pend;   // tick not yet seen by that drive
    logic tick;

    assign cur_state = state[scan_drv];

    // drives 0 to 6 pick up the tick on their next scan
    assign tick = step_tick || tick_pend[scan_drv];

    // seek checks the cylinder and search also track and sector
    assign bad_addr = (ex.dc > max_cyl) ||
                      ((ex.fc == fn_search) &&
                       ((ex.da.f.trk > max_trk) || (ex.da.f.sec > max_sec)));

    always_comb begin
        ex.finish     = 1'b0;
        ex.attn       = 1'b0;
        ex.err_iae    = 1'b0;
        ex.err_ilf    = 1'b0;
        ex.clr_status = 1'b0;
        ex.set_vv     = 1'b0;
        ex.preset     = 1'b0;
        ex.load_cc    = 1'b0;
        ex.next_cc    = ex.cc;
        ex.clr_fresh  = 1'b0;
        ex.pip        = (cur_state == seq_pos) || (cur_state == seq_first);
        nxt_state     = cur_state;
        nxt_cnt       = first_cnt[scan_drv];

        if (!ex.go) begin
            nxt_state = seq_idle;  // go dropped by controller clear
        end else begin
            case (cur_state)
                seq_idle: if (ex.fresh) begin
                    ex.clr_fresh = 1'b1;
                    case (ex.fc)
                        fn_nop:
                            ex.finish = 1'b1;
                        fn_drive_clear, fn_release: begin
                            ex.finish     = 1'b1;
                            ex.clr_status = 1'b1;
                        end
                        fn_seek, fn_search: begin
                            if (bad_addr) begin
                                ex.err_iae = 1'b1;
                                ex.attn    = 1'b1;
                                ex.finish  = 1'b1;
                            end else if (ex.dc == ex.cc) begin
                                ex.attn   = 1'b1;  // already on cylinder
                                ex.finish = 1'b1;
                            end else begin
                                nxt_state = seq_first;
                                nxt_cnt   = '0;
                            end
                        end
                        fn_recal, fn_unload: begin
                            ex.load_cc = 1'b1;
                            ex.next_cc = recal_start_cyl;  // long walk home
                            nxt_state  = seq_recal;
                        end
                        fn_preset: begin
                            ex.set_vv = 1'b1;
                            ex.preset = 1'b1;
                            ex.finish = 1'b1;
                        end
                        fn_pack_ack: begin
                            ex.set_vv = 1'b1;
                            ex.finish = 1'b1;
                        end
                        default: begin
                            // transfers, offset, anything unknown
                            ex.err_ilf = 1'b1;
                            ex.attn    = 1'b1;
                            ex.finish  = 1'b1;
                        end
                    endcase
                end
                seq_first: if (tick) begin
                    if (first_cnt[scan_drv] == first_step_ticks - 1)
                        nxt_state = seq_pos;
                    else
                        nxt_cnt = first_cnt[scan_drv] + 1'b1;
                end
                seq_pos: if (tick) begin
                    if (ex.cc == ex.dc) begin
                        ex.attn   = 1'b1;
                        ex.finish = 1'b1;
                        nxt_state = seq_idle;
                    end else begin
                        ex.load_cc = 1'b1;  // one cylinder per tick
                        ex.next_cc = (ex.cc < ex.dc) ? ex.cc + 10'd1 : ex.cc - 10'd1;
                    end
                end
                default: if (tick) begin  // recal
                    if (ex.cc == '0) begin
                        ex.attn   = 1'b1;
                        ex.finish = 1'b1;
                        nxt_state = seq_idle;
                    end else begin
                        ex.load_cc = 1'b1;
                        ex.next_cc = ex.cc - 10'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            for (int i = 0; i < num_drives; i++)
                state[i] <= seq_idle;
            tick_pend <= '0;
        end else begin
            state[scan_drv] <= nxt_state;  // only the scanned drive moves
            if (step_tick)
                tick_pend <= '1;
            tick_pend[scan_drv] <= 1'b0;   // used up by this scan
        end
        first_cnt[scan_drv] <= nxt_cnt;
    end

endmodule

//--- drive_exec/step_timer.sv
// ##############################
// drive scan and step tick
// ##############################
`timescale 1ns/1ps

module step_timer import rh11_pkg::*; (
    input  logic       CLOCK,
    input  logic       RESET,
    output drive_idx_t scan_drv,
    output logic       step_tick
);

    logic [$clog2(step_period)-1:0] round;  // scan rounds since last tick

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            scan_drv <= '0;
            round    <= '0;
        end else begin
            scan_drv <= scan_drv + 3'd1;   // round robin with one drive per clock
            if (scan_drv == 3'd7) begin
                // end of a full round
                if (round == step_period - 1)
                    round <= '0;
                else
                    round <= round + 1'b1;
            end
        end
    end

    // one tick per step_period rounds in drive 7's slot
    assign step_tick = (scan_drv == 3'd7) && (round == '0);

endmodule

//--- register_file/rh11_regs.sv
// ##############################
// rh11 register file
// ##############################
`timescale 1ns/1ps

module rh11_regs import rh11_pkg::*; (
    input  logic        CLOCK,
    input  logic        RESET,
    input  logic [17:0] a_in_h,
    input  logic [1:0]  c_in_h,
    input  word_t       d_in_h,
    input  logic        init_in_h,
    input  logic        msyn_in_h,
    output word_t       d_out_h,
    output logic        ssyn_out_h,
    input  logic        intgnt,
    input  logic [7:0]  igvec,
    output logic        intreq,
    input  drive_idx_t  scan_drv,
    drive_exec_if.regs  ex
);

    // controller registers
    logic       ie, pge;
    drive_idx_t sel;                // rpcs2 unit select
    word_t      wc, ba;
    logic       clr_busy;           // controller clear walking the drives
    drive_idx_t clr_drv;

    // per-drive registers
    logic [4:0] fc  [num_drives];
    rpda_t      da  [num_drives];
    cyl_t       dc  [num_drives];
    cyl_t       cc  [num_drives];
    word_t      er1 [num_drives];
    logic [num_drives-1:0] go, fresh, ata, err, dry, vv, pip;

    word_t      rd_word;
    logic [3:0] sn_digit;
    logic       hit, wrhi, wrlo;

    assign hit      = msyn_in_h && (a_in_h[17:6] == base_addr[17:6]);
    assign wrhi     = !c_in_h[0] || a_in_h[0];     // word or odd byte
    assign wrlo     = !c_in_h[0] || !a_in_h[0];    // word or even byte
    assign sn_digit = {1'b0, sel} + 4'd1;
    assign intreq   = ie && (ata != '0);

    // scanned drive out to the sequencer
    assign ex.fc    = fc[scan_drv];
    assign ex.go    = go[scan_drv];
    assign ex.fresh = fresh[scan_drv];
    assign ex.dc    = dc[scan_drv];
    assign ex.cc    = cc[scan_drv];
    assign ex.da    = da[scan_drv];

    always_comb begin
        rd_word = '0;
        case (reg_sel_e'(a_in_h[5:1]))
            // sc, tre, dva=1, rdy=1
            reg_cs1: rd_word = {pge || (ata != '0), pge, 3'b001, 3'b000, 1'b1, ie,
                                fc[sel], go[sel]};
            reg_wc:  rd_word = wc;
            reg_ba:  rd_word = {ba[15:1], 1'b0};
            reg_da:  rd_word = {3'b0, da[sel].f.trk, 3'b0, da[sel].f.sec};
            reg_cs2: rd_word = {5'b0, pge, 7'b0, sel};
            // ata err pip mol wrl lst pgm dpr dry vv
            reg_ds:  rd_word = {ata[sel], err[sel], pip[sel], 1'b1, 2'b00, 2'b01,
                                dry[sel], vv[sel], 6'b0};
            reg_er1: rd_word = er1[sel];
            reg_as:  rd_word = {8'b0, ata};
            reg_la:  rd_word = '0;              // no look-ahead
            reg_dt:  rd_word = drive_type_rp06;
            reg_sn:  rd_word = {4{sn_digit}};
            reg_of:  rd_word = offset_word;
            reg_dc:  rd_word = {6'b0, dc[sel]};
            reg_cc:  rd_word = {6'b0, cc[sel]};
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            ie         <= 1'b0;
            pge        <= 1'b0;
            sel        <= '0;
            clr_busy   <= 1'b1;             // walk the drives once out of reset
            clr_drv    <= '0;
            go         <= '0;
            fresh      <= '0;
            ata        <= '0;
            err        <= '0;
            dry        <= '1;
            vv         <= '0;
            pip        <= '0;
            ssyn_out_h <= 1'b0;
            d_out_h    <= '0;
        end else if (init_in_h) begin
            clr_busy   <= 1'b1;             // clear starts when init drops
            clr_drv    <= '0;
            pge        <= 1'b0;
            sel        <= '0;
            ssyn_out_h <= 1'b0;
            d_out_h    <= '0;
        end else begin
            if (clr_busy) begin
                // one drive per cycle
                fc[clr_drv]      <= '0;
                go[clr_drv]      <= 1'b0;
                fresh[clr_drv]   <= 1'b0;
                da[clr_drv].raw  <= '0;
                dc[clr_drv]      <= '0;
                cc[clr_drv]      <= '0;
                er1[clr_drv]     <= '0;
                ata[clr_drv]     <= 1'b0;
                err[clr_drv]     <= 1'b0;
                dry[clr_drv]     <= 1'b1;
                vv[clr_drv]      <= 1'b0;
                pip[clr_drv]     <= 1'b0;
                ie               <= 1'b0;
                wc               <= '0;
                ba               <= '0;
                clr_drv          <= clr_drv + 3'd1;
                if (clr_drv == 3'd7)
                    clr_busy <= 1'b0;
            end

            // bus slave holds off new cycles during controller clear
            if (!msyn_in_h && ssyn_out_h) begin
                ssyn_out_h <= 1'b0;
                d_out_h    <= '0;
            end else if (hit && !ssyn_out_h && !clr_busy) begin
                ssyn_out_h <= 1'b1;
                if (!c_in_h[1]) begin
                    d_out_h <= rd_word;
                end else begin
                    case (reg_sel_e'(a_in_h[5:1]))
                        reg_cs1: begin
                            if (wrhi && d_in_h[14])
                                pge <= 1'b0;    // tre write clears errors
                            if (wrlo) begin
                                ie <= d_in_h[6];
                                if (d_in_h[0]) begin
                                    if (!dry[sel]) begin
                                        pge <= 1'b1;    // drive busy
                                    end else begin
                                        fc[sel]    <= d_in_h[5:1];
                                        go[sel]    <= 1'b1;
                                        fresh[sel] <= 1'b1;
                                        dry[sel]   <= 1'b0;
                                    end
                                end
                            end
                        end
                        reg_wc: begin
                            if (wrhi) wc[15:8] <= d_in_h[15:8];
                            if (wrlo) wc[7:0]  <= d_in_h[7:0];
                        end
                        reg_ba: begin
                            if (wrhi) ba[15:8] <= d_in_h[15:8];
                            if (wrlo) ba[7:0]  <= d_in_h[7:0];
                        end
                        reg_da: begin
                            if (wrhi) da[sel].raw[15:8] <= d_in_h[15:8];
                            if (wrlo) da[sel].raw[7:0]  <= d_in_h[7:0];
                        end
                        reg_cs2: if (wrlo) begin
                            if (d_in_h[5]) begin
                                clr_busy <= 1'b1;   // clr bit
                                clr_drv  <= '0;
                                pge      <= 1'b0;
                            end else begin
                                sel <= d_in_h[2:0];
                            end
                        end
                        reg_er1: begin
                            if (wrhi) er1[sel][15:8] <= d_in_h[15:8];
                            if (wrlo) er1[sel][7:0]  <= d_in_h[7:0];
                        end
                        reg_as: if (wrlo) ata <= ata & ~d_in_h[7:0];  // write one to clear
                        reg_dc: begin
                            if (wrhi) dc[sel][9:8] <= d_in_h[9:8];
                            if (wrlo) dc[sel][7:0] <= d_in_h[7:0];
                        end
                        default: ;              // read-only or unused
                    endcase
                end
            end

            // sequencer strobes land last so no drive event is lost
            if (!clr_busy) begin
                pip[scan_drv] <= ex.pip;
                if (ex.clr_fresh) fresh[scan_drv] <= 1'b0;
                if (ex.clr_status) begin
                    ata[scan_drv] <= 1'b0;
                    err[scan_drv] <= 1'b0;
                    er1[scan_drv] <= '0;
                end
                if (ex.err_iae) begin
                    er1[scan_drv][10] <= 1'b1;
                    err[scan_drv]     <= 1'b1;
                end
                if (ex.err_ilf) begin
                    er1[scan_drv][0] <= 1'b1;
                    err[scan_drv]    <= 1'b1;
                end
                if (ex.attn)    ata[scan_drv] <= 1'b1;
                if (ex.set_vv)  vv[scan_drv]  <= 1'b1;
                if (ex.load_cc) cc[scan_drv]  <= ex.next_cc;
                if (ex.preset) begin
                    da[scan_drv].f.trk <= '0;
                    da[scan_drv].f.sec <= '0;
                    dc[scan_drv]       <= '0;
                end
                if (ex.finish) begin
                    go[scan_drv]  <= 1'b0;
                    dry[scan_drv] <= 1'b1;
                end
            end

            // ie drops once our vector is granted
            if (intgnt && (igvec == int_vector))
                ie <= 1'b0;
        end
    end

endmodule

//--- rh11.f
common/rh11_pkg.sv
common/drive_exec_if.sv
drive_exec/step_timer.sv
drive_exec/drive_sequencer.sv
register_file/rh11_regs.sv
source/rh11_top.sv
verif/rh11_assertions.sv
verif/rh11_tb.sv

//--- source/rh11_top.sv
// ##############################
// rh11 controller top
// ##############################
`timescale 1ns/1ps

module rh11_top import rh11_pkg::*; (
    input  logic        CLOCK,
    input  logic        RESET,

    // unibus slave side
    input  logic [17:0] a_in_h,
    input  logic [1:0]  c_in_h,
    input  word_t       d_in_h,
    input  logic        init_in_h,
    input  logic        msyn_in_h,
    output word_t       d_out_h,
    output logic        ssyn_out_h,

    // interrupt
    output logic        intreq,
    output logic [7:0]  irvec,
    input  logic        intgnt,
    input  logic [7:0]  igvec
);

    drive_idx_t scan_drv;   // drive being serviced this cycle
    logic       step_tick;

    drive_exec_if ex ();

    step_timer u_timer (
        .CLOCK     (CLOCK),
        .RESET     (RESET),
        .scan_drv  (scan_drv),
        .step_tick (step_tick)
    );

    rh11_regs u_regs (
        .CLOCK      (CLOCK),
        .RESET      (RESET),
        .a_in_h     (a_in_h),
        .c_in_h     (c_in_h),
        .d_in_h     (d_in_h),
        .init_in_h  (init_in_h),
        .msyn_in_h  (msyn_in_h),
        .d_out_h    (d_out_h),
        .ssyn_out_h (ssyn_out_h),
        .intgnt     (intgnt),
        .igvec      (igvec),
        .intreq     (intreq),
        .scan_drv   (scan_drv),
        .ex         (ex.regs)
    );

    drive_sequencer u_seq (
        .CLOCK     (CLOCK),
        .RESET     (RESET),
        .scan_drv  (scan_drv),
        .step_tick (step_tick),
        .ex        (ex.seq)
    );

    assign irvec = int_vector;  // fixed vector

endmodule

//--- verif/rh11_assertions.sv
// ##############################
// bus and interrupt assertions
// ##############################
`timescale 1ns/1ps

module rh11_assertions import rh11_pkg::*; (
    input logic       CLOCK,
    input logic       RESET,
    input logic       msyn_in_h,
    input logic       ssyn_out_h,
    input word_t      d_out_h,
    input logic       intreq,
    input logic       intgnt,
    input logic [7:0] igvec
);

    // slave answers only a master
    ssyn_needs_msyn: assert property (@(posedge CLOCK) disable iff (RESET)
        $rose(ssyn_out_h) |-> $past(msyn_in_h))
        else $error("ssyn rose without msyn");

    // data lines idle between cycles
    data_idle: assert property (@(posedge CLOCK) disable iff (RESET)
        !ssyn_out_h |-> (d_out_h == '0))
        else $error("d_out_h not zero while ssyn low");

    // request drops once our vector is granted
    grant_drops_intreq: assert property (@(posedge CLOCK) disable iff (RESET)
        (intgnt && (igvec == int_vector)) |=> !intreq)
        else $error("intreq still high after our vector was granted");

endmodule

bind rh11_regs rh11_assertions u_assert (
    .CLOCK      (CLOCK),
    .RESET      (RESET),
    .msyn_in_h  (msyn_in_h),
    .ssyn_out_h (ssyn_out_h),
    .d_out_h    (d_out_h),
    .intreq     (intreq),
    .intgnt     (intgnt),
    .igvec      (igvec)
);

//--- verif/rh11_tb.sv
// ##############################
// rh11 testbench
// ##############################
`timescale 1ns/1ps

module rh11_tb import rh11_pkg::*; ();

    logic        CLOCK;
    logic        RESET;
    logic [17:0] a_in_h;
    logic [1:0]  c_in_h;        // [1] write, [0] byte
    word_t       d_in_h;
    logic        init_in_h;
    logic        msyn_in_h;
    word_t       d_out_h;
    logic        ssyn_out_h;
    logic        intreq;
    logic [7:0]  irvec;
    logic        intgnt;
    logic [7:0]  igvec;

    localparam int ssyn_limit = 64;    // in cycles and longer than a controller clear
    // in polls since every read costs at least 4 cycles
    localparam int dry_limit =
        (first_step_ticks + int'(max_cyl) + 4) * step_period * num_drives / 2;

    // drive model
    cyl_t                  m_cc  [num_drives];
    cyl_t                  m_dc  [num_drives];
    word_t                 m_da  [num_drives];
    word_t                 m_er1 [num_drives];
    logic [num_drives-1:0] m_ata, m_err, m_vv;
    logic                  m_pge;
    integer                seed;

    rh11_top uut (.*);

    initial begin
        CLOCK = 1'b0;
        forever #5 CLOCK = ~CLOCK;
    end

    // expected register word for an idle drive
    function automatic word_t exp_reg(reg_sel_e sel, drive_idx_t drv);
        word_t      w;
        logic [3:0] digit;
        digit = {1'b0, drv} + 4'd1;
        case (sel)
            // ata err pip mol | wrl lst pgm dpr | dry vv
            reg_ds:  w = {m_ata[drv], m_err[drv], 2'b01, 3'b000, 2'b11, m_vv[drv], 6'b0};
            reg_er1: w = m_er1[drv];
            reg_as:  w = {8'b0, m_ata};
            reg_cs2: w = {5'b0, m_pge, 7'b0, drv};     // pge at bit 10
            reg_da:  w = m_da[drv] & 16'o017437;       // track and sector fields
            reg_dt:  w = drive_type_rp06;
            reg_sn:  w = {4{digit}};
            reg_of:  w = offset_word;
            reg_dc:  w = {6'b0, m_dc[drv]};
            reg_cc:  w = {6'b0, m_cc[drv]};
            default: w = '0;                           // la and unused
        endcase
        return w;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            stop_run($sformatf("CHECK FAILED %s expected %06o actual %06o", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
    endtask

    // ssyn sampled on the falling edge
    task automatic wait_ssyn(input logic level);
        int n;
        n = 0;
        @(negedge CLOCK);
        while (ssyn_out_h !== level) begin
            n++;
            if (n > ssyn_limit)
                stop_run("timeout, the DUT never answered on ssyn");
            @(negedge CLOCK);
        end
    endtask

    task automatic bus_write(input reg_sel_e sel, input word_t data);
        @(posedge CLOCK);
        a_in_h    <= base_addr + 18'({sel, 1'b0});
        c_in_h    <= 2'b10;        // word write
        d_in_h    <= data;
        msyn_in_h <= 1'b1;
        wait_ssyn(1'b1);
        @(posedge CLOCK);
        msyn_in_h <= 1'b0;
        wait_ssyn(1'b0);
    endtask

    task automatic bus_read(input reg_sel_e sel, output word_t data);
        @(posedge CLOCK);
        a_in_h    <= base_addr + 18'({sel, 1'b0});
        c_in_h    <= 2'b00;
        msyn_in_h <= 1'b1;
        wait_ssyn(1'b1);
        data = d_out_h;            // valid with ssyn
        @(posedge CLOCK);
        msyn_in_h <= 1'b0;
        wait_ssyn(1'b0);
    endtask

    task automatic select_drive(input drive_idx_t drv);
        bus_write(reg_cs2, {13'b0, drv});
    endtask

    task automatic start_cmd(input logic [4:0] fn, input logic ie);
        bus_write(reg_cs1, {9'b0, ie, fn, 1'b1});   // go set
    endtask

    // poll rpds of the selected drive until dry and not pip
    task automatic wait_dry();
        word_t ds;
        int    polls;
        polls = 0;
        bus_read(reg_ds, ds);
        while (!ds[7] || ds[13]) begin
            polls++;
            if (polls > dry_limit)
                stop_run("timeout, the drive never returned to ready");
            bus_read(reg_ds, ds);
        end
    endtask

    task automatic pulse_grant(input logic [7:0] vec);
        @(posedge CLOCK);
        intgnt <= 1'b1;
        igvec  <= vec;
        @(posedge CLOCK);
        intgnt <= 1'b0;
        igvec  <= '0;
        @(negedge CLOCK);          // ie update visible here
    endtask

    initial begin
        word_t      rd;
        word_t      raw;
        cyl_t       target;
        drive_idx_t drv;
        seed      = 13;
        RESET     = 1'b1;
        a_in_h    = '0;
        c_in_h    = '0;
        d_in_h    = '0;
        init_in_h = 1'b0;
        msyn_in_h = 1'b0;
        intgnt    = 1'b0;
        igvec     = '0;
        m_ata     = '0;
        m_err     = '0;
        m_vv      = '0;
        m_pge     = 1'b0;
        for (int i = 0; i < num_drives; i++) begin
            m_cc[i]  = '0;
            m_dc[i]  = '0;
            m_da[i]  = '0;
            m_er1[i] = '0;
        end
        repeat (16) @(posedge CLOCK);
        RESET <= 1'b0;
        @(posedge CLOCK);
        init_in_h <= 1'b1;         // clear walks the drives once init drops
        repeat (4) @(posedge CLOCK);
        init_in_h <= 1'b0;

        // constant registers of every drive
        for (int i = 0; i < num_drives; i++) begin
            select_drive(drive_idx_t'(i));
            bus_read(reg_ds, rd);
            check_word("const rpds", exp_reg(reg_ds, drive_idx_t'(i)), rd);
            check_bit("const dry", 1'b1, rd[7]);
            check_bit("const vv", 1'b0, rd[6]);
            bus_read(reg_dt, rd);
            check_word("const rpdt", exp_reg(reg_dt, drive_idx_t'(i)), rd);
            bus_read(reg_sn, rd);
            check_word("const rpsn", exp_reg(reg_sn, drive_idx_t'(i)), rd);
            bus_read(reg_of, rd);
            check_word("const rpof", exp_reg(reg_of, drive_idx_t'(i)), rd);
            bus_read(reg_la, rd);
            check_word("const rpla", exp_reg(reg_la, drive_idx_t'(i)), rd);
        end

        // random seeks on drives 0 to 2
        for (int i = 0; i < 3; i++) begin
            drv = drive_idx_t'(i);
            select_drive(drv);
            target = cyl_t'($unsigned($random(seed)) % (int'(max_cyl) + 1));
            bus_write(reg_dc, {6'b0, target});
            start_cmd(fn_seek, 1'b0);
            wait_dry();
            m_dc[drv]  = target;
            m_cc[drv]  = target;
            m_ata[drv] = 1'b1;
            bus_read(reg_cc, rd);
            check_word("seek rpcc", exp_reg(reg_cc, drv), rd);
            bus_read(reg_ds, rd);
            check_word("seek rpds", exp_reg(reg_ds, drv), rd);
            bus_read(reg_as, rd);
            check_word("seek rpas", exp_reg(reg_as, drv), rd);
            bus_write(reg_as, word_t'(1) << drv);      // write one to clear
            m_ata[drv] = 1'b0;
            bus_read(reg_as, rd);
            check_word("seek ata clear", exp_reg(reg_as, drv), rd);
        end

        // go while positioning
        select_drive(3'd7);
        target = (m_cc[7] > 10'd10) ? m_cc[7] - 10'd5 : m_cc[7] + 10'd5;
        bus_write(reg_dc, {6'b0, target});
        start_cmd(fn_seek, 1'b0);
        bus_read(reg_ds, rd);
        check_bit("busy dry", 1'b0, rd[7]);
        start_cmd(fn_nop, 1'b0);
        m_pge = 1'b1;
        bus_read(reg_cs2, rd);
        check_word("busy pge", exp_reg(reg_cs2, 3'd7), rd);
        wait_dry();
        m_dc[7]  = target;
        m_cc[7]  = target;
        m_ata[7] = 1'b1;
        bus_read(reg_cc, rd);
        check_word("busy rpcc", exp_reg(reg_cc, 3'd7), rd);
        bus_write(reg_cs1, 16'o040000);                // tre drops pge
        m_pge = 1'b0;
        bus_read(reg_cs2, rd);
        check_word("pge clear", exp_reg(reg_cs2, 3'd7), rd);
        bus_write(reg_as, 16'h0080);
        m_ata[7] = 1'b0;

        // seek past the last cylinder
        select_drive(3'd5);
        bus_write(reg_dc, {6'b0, max_cyl + 10'd1});
        start_cmd(fn_seek, 1'b0);
        wait_dry();
        m_dc[5]  = max_cyl + 10'd1;
        m_er1[5] = 16'o002000;     // iae
        m_err[5] = 1'b1;
        m_ata[5] = 1'b1;
        bus_read(reg_er1, rd);
        check_word("iae rper1", exp_reg(reg_er1, 3'd5), rd);
        bus_read(reg_ds, rd);
        check_word("iae rpds", exp_reg(reg_ds, 3'd5), rd);
        bus_read(reg_as, rd);
        check_word("iae rpas", exp_reg(reg_as, 3'd5), rd);
        start_cmd(fn_drive_clear, 1'b0);
        wait_dry();
        m_er1[5] = '0;
        m_err[5] = 1'b0;
        m_ata[5] = 1'b0;
        bus_read(reg_er1, rd);
        check_word("dclr rper1", exp_reg(reg_er1, 3'd5), rd);
        bus_read(reg_ds, rd);
        check_word("dclr rpds", exp_reg(reg_ds, 3'd5), rd);
        bus_read(reg_as, rd);
        check_word("dclr rpas", exp_reg(reg_as, 3'd5), rd);

        // read data is no longer a legal function
        select_drive(3'd6);
        start_cmd(5'o34, 1'b0);
        wait_dry();
        m_er1[6] = 16'o000001;     // ilf
        m_err[6] = 1'b1;
        m_ata[6] = 1'b1;
        bus_read(reg_er1, rd);
        check_word("ilf rper1", exp_reg(reg_er1, 3'd6), rd);
        bus_read(reg_ds, rd);
        check_word("ilf rpds", exp_reg(reg_ds, 3'd6), rd);
        start_cmd(fn_drive_clear, 1'b0);
        wait_dry();
        m_er1[6] = '0;
        m_err[6] = 1'b0;
        m_ata[6] = 1'b0;

        // preset
        raw    = word_t'($random(seed));
        target = cyl_t'($unsigned($random(seed)) % (int'(max_cyl) + 1));
        bus_write(reg_da, raw);
        bus_write(reg_dc, {6'b0, target});
        m_da[6] = raw;
        m_dc[6] = target;
        bus_read(reg_da, rd);
        check_word("rpda fields", exp_reg(reg_da, 3'd6), rd);
        start_cmd(fn_preset, 1'b0);
        wait_dry();
        m_da[6] = '0;
        m_dc[6] = '0;
        m_vv[6] = 1'b1;
        bus_read(reg_da, rd);
        check_word("preset rpda", exp_reg(reg_da, 3'd6), rd);
        bus_read(reg_dc, rd);
        check_word("preset rpdc", exp_reg(reg_dc, 3'd6), rd);
        bus_read(reg_ds, rd);
        check_word("preset rpds", exp_reg(reg_ds, 3'd6), rd);

        // attention interrupt from an on-cylinder seek with ie
        select_drive(3'd2);
        @(negedge CLOCK);
        check_bit("intreq idle", 1'b0, intreq);
        bus_write(reg_dc, {6'b0, m_cc[2]});
        start_cmd(fn_seek, 1'b1);
        wait_dry();
        m_ata[2] = 1'b1;
        bus_read(reg_as, rd);
        check_word("int rpas", exp_reg(reg_as, 3'd2), rd);
        @(negedge CLOCK);
        check_bit("intreq set", 1'b1, intreq);
        check_word("irvec", word_t'(int_vector), word_t'(irvec));
        pulse_grant(8'o100);       // some other device's vector
        check_bit("intreq other grant", 1'b1, intreq);
        pulse_grant(int_vector);
        check_bit("intreq granted", 1'b0, intreq);

        $display("Simulation passed");
        $finish;
    end

endmodule
